//--- rtl/mem_msg_pkg.sv
// ######################################
// single-beat messages only, sizes of 1 to 8 bytes
// ######################################
`default_nettype none

package mem_msg_pkg;

  typedef enum logic [0:0]
  {
    e_mem_rd = 1'b0,
    e_mem_wr = 1'b1
  } msg_type_e;

  // log2 of the transfer size in bytes
  typedef enum logic [1:0]
  {
    e_size_1 = 2'd0,
    e_size_2 = 2'd1,
    e_size_4 = 2'd2,
    e_size_8 = 2'd3
  } msg_size_e;

  typedef logic [3:0] msg_id_t;

  // spread the low 2^size bytes over one 64-bit lane
  function automatic logic [63:0] replicate_bytes(input logic [63:0] word, input msg_size_e size);
    logic [63:0] rep;
    case (size)
      e_size_1: rep = {8{word[7:0]}};
      e_size_2: rep = {4{word[15:0]}};
      e_size_4: rep = {2{word[31:0]}};
      default:  rep = word;
    endcase
    return rep;
  endfunction

endpackage

`default_nettype wire

//--- rtl/cache_op_pkg.sv
// ######################################
// opcode subset for single-beat B/H/W/D traffic
// ######################################
`default_nettype none

package cache_op_pkg;

  // cache operations, TAGST is only used during init
  typedef enum logic [3:0]
  {
    LB    = 4'd0,
    LH    = 4'd1,
    LW    = 4'd2,
    LD    = 4'd3,
    SB    = 4'd4,
    SH    = 4'd5,
    SW    = 4'd6,
    SD    = 4'd7,
    TAGST = 4'd8
  } cache_opcode_e;

  // 64-byte cache blocks
  localparam int block_offset_width_c = 6;

endpackage

`default_nettype wire

//--- rtl/cmd_to_cache_pkt.sv
// ######################################
// combinational, data_width_p a power of two >= 64
// ######################################
`timescale 1ns/1ps
`default_nettype none

module cmd_to_cache_pkt
#(
  parameter int data_width_p = 64,
  parameter int addr_width_p = 28
)
(
  input  mem_msg_pkg::msg_type_e         type_i,
  input  mem_msg_pkg::msg_size_e         size_i,
  input  logic [addr_width_p-1:0]        addr_i,
  input  logic [data_width_p-1:0]        data_i,
  output cache_op_pkg::cache_opcode_e    opcode_o,
  output logic [addr_width_p-1:0]        addr_o,
  output logic [data_width_p-1:0]        data_o
);

  import mem_msg_pkg::*;
  import cache_op_pkg::*;

  localparam int lanes_lp = data_width_p / 64;

  logic [63:0] store_lane;

  // write data is the low 2^size bytes repeated in every 64-bit lane
  assign store_lane = replicate_bytes(data_i[63:0], size_i);

  always_comb
  begin
    opcode_o = LB;
    data_o   = '0;
    if (type_i == e_mem_wr)
    begin
      data_o = {lanes_lp{store_lane}};
      case (size_i)
        e_size_1: opcode_o = SB;
        e_size_2: opcode_o = SH;
        e_size_4: opcode_o = SW;
        default:  opcode_o = SD;
      endcase
    end
    else
    begin
      // loads carry no data
      case (size_i)
        e_size_1: opcode_o = LB;
        e_size_2: opcode_o = LH;
        e_size_4: opcode_o = LW;
        default:  opcode_o = LD;
      endcase
    end
  end

  // the cache takes the byte address as is
  assign addr_o = addr_i;

endmodule

`default_nettype wire

//--- rtl/resp_header_fifo.sv
// ######################################
// fifo_els_p must be a power of two, at least 2
// ######################################
`timescale 1ns/1ps
`default_nettype none

module resp_header_fifo
#(
  parameter int addr_width_p = 28,
  parameter int fifo_els_p   = 4
)
(
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       v_i,
  input  mem_msg_pkg::msg_type_e     type_i,
  input  mem_msg_pkg::msg_size_e     size_i,
  input  mem_msg_pkg::msg_id_t       id_i,
  input  logic [addr_width_p-1:0]    addr_i,
  output logic                       ready_o,
  output logic                       v_o,
  output mem_msg_pkg::msg_type_e     type_o,
  output mem_msg_pkg::msg_size_e     size_o,
  output mem_msg_pkg::msg_id_t       id_o,
  output logic [addr_width_p-1:0]    addr_o,
  input  logic                       yumi_i
);

  import mem_msg_pkg::*;

  localparam int lg_els_lp = $clog2(fifo_els_p);

  msg_type_e                type_mem [fifo_els_p];
  msg_size_e                size_mem [fifo_els_p];
  msg_id_t                  id_mem   [fifo_els_p];
  logic [addr_width_p-1:0]  addr_mem [fifo_els_p];

  // extra msb tells full from empty when the indices match
  logic [lg_els_lp:0] wr_ptr_r;
  logic [lg_els_lp:0] rd_ptr_r;
  logic               push;
  logic               pop;

  assign v_o     = (wr_ptr_r != rd_ptr_r);
  assign ready_o = (wr_ptr_r != {~rd_ptr_r[lg_els_lp], rd_ptr_r[lg_els_lp-1:0]});
  assign push    = v_i & ready_o;
  assign pop     = yumi_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_r <= wr_ptr_r + 1'b1;
      if (pop)
        rd_ptr_r <= rd_ptr_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      type_mem[wr_ptr_r[lg_els_lp-1:0]] <= type_i;
      size_mem[wr_ptr_r[lg_els_lp-1:0]] <= size_i;
      id_mem[wr_ptr_r[lg_els_lp-1:0]]   <= id_i;
      addr_mem[wr_ptr_r[lg_els_lp-1:0]] <= addr_i;
    end
  end

  // oldest header, read straight from storage
  assign type_o = type_mem[rd_ptr_r[lg_els_lp-1:0]];
  assign size_o = size_mem[rd_ptr_r[lg_els_lp-1:0]];
  assign id_o   = id_mem[rd_ptr_r[lg_els_lp-1:0]];
  assign addr_o = addr_mem[rd_ptr_r[lg_els_lp-1:0]];

endmodule

`default_nettype wire

//--- rtl/tag_clear_seq.sv
// ######################################
// one TAGST per line, one reply expected per packet
// ######################################
`timescale 1ns/1ps
`default_nettype none

module tag_clear_seq
#(
  parameter int addr_width_p = 28,
  parameter int sets_p       = 8,
  parameter int assoc_p      = 2
)
(
  input  logic                      clk_i,
  input  logic                      reset_i,
  output logic                      pkt_v_o,
  output logic [addr_width_p-1:0]   pkt_addr_o,
  input  logic                      pkt_ready_i,
  input  logic                      data_v_i,
  output logic                      data_yumi_o,
  output logic                      done_o
);

  import cache_op_pkg::*;

  localparam int lines_lp     = sets_p * assoc_p;
  localparam int cnt_width_lp = $clog2(lines_lp + 1);
  localparam logic [cnt_width_lp-1:0] lines_cnt_lp = lines_lp[cnt_width_lp-1:0];

  typedef enum logic [1:0] {e_reset, e_clear, e_ready} state_e;

  state_e                  state_r;
  state_e                  state_n;
  logic [cnt_width_lp-1:0] sent_r;
  logic [cnt_width_lp-1:0] sent_n;
  logic [cnt_width_lp-1:0] recv_r;
  logic [cnt_width_lp-1:0] recv_n;

  // line index goes straight into the set/way bits above the block offset
  assign pkt_addr_o = addr_width_p'(sent_r) << block_offset_width_c;
  assign done_o     = (state_r == e_ready);

  always_comb
  begin
    state_n     = state_r;
    sent_n      = sent_r;
    recv_n      = recv_r;
    pkt_v_o     = 1'b0;
    data_yumi_o = 1'b0;
    case (state_r)
      e_reset:
        state_n = e_clear;
      e_clear:
      begin
        pkt_v_o     = (sent_r != lines_cnt_lp);
        // every reply during init is a TAGST ack, just count it
        data_yumi_o = data_v_i;
        if (pkt_v_o && pkt_ready_i)
          sent_n = sent_r + 1'b1;
        if (data_yumi_o)
          recv_n = recv_r + 1'b1;
        if ((sent_n == lines_cnt_lp) && (recv_n == lines_cnt_lp))
          state_n = e_ready;
      end
      default:
        state_n = e_ready;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_reset;
      sent_r  <= '0;
      recv_r  <= '0;
    end
    else
    begin
      state_r <= state_n;
      sent_r  <= sent_n;
      recv_r  <= recv_n;
    end
  end

endmodule

`default_nettype wire

//--- rtl/mem_to_cache_bridge.sv
// ######################################
// single bank, single-beat commands, in-order cache
// no command is taken until all TAGST replies are back
// ######################################
`timescale 1ns/1ps
`default_nettype none

module mem_to_cache_bridge
#(
  parameter int data_width_p = 64,
  parameter int addr_width_p = 28,
  parameter int sets_p       = 8,
  parameter int assoc_p      = 2,
  parameter int fifo_els_p   = 4
)
(
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          cmd_v_i,
  input  mem_msg_pkg::msg_type_e        cmd_type_i,
  input  mem_msg_pkg::msg_size_e        cmd_size_i,
  input  mem_msg_pkg::msg_id_t          cmd_id_i,
  input  logic [addr_width_p-1:0]       cmd_addr_i,
  input  logic [data_width_p-1:0]       cmd_data_i,
  output logic                          cmd_ready_o,
  output logic                          cache_pkt_v_o,
  output cache_op_pkg::cache_opcode_e   cache_opcode_o,
  output logic [addr_width_p-1:0]       cache_addr_o,
  output logic [data_width_p-1:0]       cache_data_o,
  input  logic                          cache_pkt_ready_i,
  input  logic                          cache_data_v_i,
  input  logic [data_width_p-1:0]       cache_data_i,
  output logic                          cache_data_yumi_o,
  output logic                          resp_v_o,
  output mem_msg_pkg::msg_type_e        resp_type_o,
  output mem_msg_pkg::msg_size_e        resp_size_o,
  output mem_msg_pkg::msg_id_t          resp_id_o,
  output logic [addr_width_p-1:0]       resp_addr_o,
  output logic [data_width_p-1:0]       resp_data_o,
  input  logic                          resp_ready_i
);

  import mem_msg_pkg::*;
  import cache_op_pkg::*;

  if ((data_width_p < 64) || ((data_width_p & (data_width_p - 1)) != 0))
  begin : g_width_check
    $error("data_width_p must be a power of two of at least 64");
  end

  logic                     init_done;
  logic                     init_pkt_v;
  logic [addr_width_p-1:0]  init_addr;
  logic                     init_yumi;
  cache_opcode_e            dec_opcode;
  logic [addr_width_p-1:0]  dec_addr;
  logic [data_width_p-1:0]  dec_data;
  logic                     fifo_ready;
  logic                     fifo_v;
  logic [63:0]              resp_lane;

  tag_clear_seq #(
    .addr_width_p (addr_width_p),
    .sets_p       (sets_p),
    .assoc_p      (assoc_p)
  ) u_tag_clear (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .pkt_v_o     (init_pkt_v),
    .pkt_addr_o  (init_addr),
    .pkt_ready_i (cache_pkt_ready_i),
    .data_v_i    (cache_data_v_i),
    .data_yumi_o (init_yumi),
    .done_o      (init_done)
  );

  cmd_to_cache_pkt #(
    .data_width_p (data_width_p),
    .addr_width_p (addr_width_p)
  ) u_decode (
    .type_i   (cmd_type_i),
    .size_i   (cmd_size_i),
    .addr_i   (cmd_addr_i),
    .data_i   (cmd_data_i),
    .opcode_o (dec_opcode),
    .addr_o   (dec_addr),
    .data_o   (dec_data)
  );

  // header is pushed on the same cycle the packet goes out
  resp_header_fifo #(
    .addr_width_p (addr_width_p),
    .fifo_els_p   (fifo_els_p)
  ) u_hdr_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (cmd_v_i & cmd_ready_o),
    .type_i  (cmd_type_i),
    .size_i  (cmd_size_i),
    .id_i    (cmd_id_i),
    .addr_i  (cmd_addr_i),
    .ready_o (fifo_ready),
    .v_o     (fifo_v),
    .type_o  (resp_type_o),
    .size_o  (resp_size_o),
    .id_o    (resp_id_o),
    .addr_o  (resp_addr_o),
    .yumi_i  (resp_v_o & resp_ready_i)
  );

  always_comb
  begin
    if (!init_done)
    begin
      // tag clearing owns both cache channels
      cache_pkt_v_o     = init_pkt_v;
      cache_opcode_o    = TAGST;
      cache_addr_o      = init_addr;
      cache_data_o      = '0;
      cmd_ready_o       = 1'b0;
      resp_v_o          = 1'b0;
      cache_data_yumi_o = init_yumi;
    end
    else
    begin
      cache_pkt_v_o     = cmd_v_i & fifo_ready;
      cache_opcode_o    = dec_opcode;
      cache_addr_o      = dec_addr;
      cache_data_o      = dec_data;
      cmd_ready_o       = fifo_ready & cache_pkt_ready_i;
      resp_v_o          = fifo_v & cache_data_v_i;
      cache_data_yumi_o = resp_v_o & resp_ready_i;
    end
  end

  // load data sits at the lsb of the cache word
  assign resp_lane   = replicate_bytes(cache_data_i[63:0], resp_size_o);
  assign resp_data_o = {(data_width_p / 64){resp_lane}};

endmodule

`default_nettype wire

//--- bench/bridge_assertions.sv
// ########################################
// bound into mem_to_cache_bridge, checks out of reset only
// ########################################
`timescale 1ns/1ps
`default_nettype none

module bridge_assertions
#(
  parameter int data_width_p = 64,
  parameter int addr_width_p = 28,
  parameter int sets_p       = 8,
  parameter int assoc_p      = 2
)
(
  input logic                      clk_i,
  input logic                      reset_i,
  input logic                      cmd_ready_i,
  input logic                      cache_data_v_i,
  input logic                      cache_data_yumi_i,
  input logic                      resp_v_i,
  input logic                      resp_ready_i,
  input mem_msg_pkg::msg_type_e    resp_type_i,
  input mem_msg_pkg::msg_size_e    resp_size_i,
  input mem_msg_pkg::msg_id_t      resp_id_i,
  input logic [addr_width_p-1:0]   resp_addr_i,
  input logic [data_width_p-1:0]   resp_data_i
);

  localparam int lines_lp = sets_p * assoc_p;

  int fail_count = 0;
  // TAGST replies consumed, saturating at one per line
  int replies_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      replies_r <= 0;
    else if (cache_data_yumi_i && (replies_r < lines_lp))
      replies_r <= replies_r + 1;
  end

  // tag clearing must finish before any command is taken
  no_cmd_before_init: assert property (@(posedge clk_i) disable iff (reset_i)
    cmd_ready_i |-> (replies_r == lines_lp))
    else
    begin
      $error("cmd_ready_o high before every TAGST reply was taken");
      fail_count++;
    end

  yumi_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    cache_data_yumi_i |-> cache_data_v_i)
    else
    begin
      $error("cache_data_yumi_o without cache_data_v_i");
      fail_count++;
    end

  // a stalled response keeps its fields
  resp_held_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (resp_v_i && !resp_ready_i) ##1 resp_v_i
      |-> $stable({resp_type_i, resp_size_i, resp_id_i, resp_addr_i, resp_data_i}))
    else
    begin
      $error("response fields changed while the response was stalled");
      fail_count++;
    end

endmodule

bind mem_to_cache_bridge bridge_assertions #(
  .data_width_p (data_width_p),
  .addr_width_p (addr_width_p),
  .sets_p       (sets_p),
  .assoc_p      (assoc_p)
) u_assertions (
  .clk_i             (clk_i),
  .reset_i           (reset_i),
  .cmd_ready_i       (cmd_ready_o),
  .cache_data_v_i    (cache_data_v_i),
  .cache_data_yumi_i (cache_data_yumi_o),
  .resp_v_i          (resp_v_o),
  .resp_ready_i      (resp_ready_i),
  .resp_type_i       (resp_type_o),
  .resp_size_i       (resp_size_o),
  .resp_id_i         (resp_id_o),
  .resp_addr_i       (resp_addr_o),
  .resp_data_i       (resp_data_o)
);

`default_nettype wire

//--- bench/bridge_tb.sv
// ########################################
// 64-bit bus only, commands kept in a 256-byte window
// ########################################
`timescale 1ns/1ps
`default_nettype none

module bridge_tb;

  import mem_msg_pkg::*;
  import cache_op_pkg::*;

  localparam int lines_lp     = 16;
  localparam int fifo_els_lp  = 4;
  localparam int mem_bytes_lp = 256;

  logic clk_i = 1'b0;
  logic reset_i, cmd_v_i, cmd_ready_o, cache_pkt_v_o, cache_pkt_ready_i;
  logic cache_data_v_i, cache_data_yumi_o, resp_v_o, resp_ready_i;
  msg_type_e cmd_type_i, resp_type_o;
  msg_size_e cmd_size_i, resp_size_o;
  msg_id_t cmd_id_i, resp_id_o;
  logic [27:0] cmd_addr_i, cache_addr_o, resp_addr_o;
  logic [63:0] cmd_data_i, cache_data_o, cache_data_i, resp_data_o;
  cache_opcode_e cache_opcode_o;

  logic [7:0] cache_mem [mem_bytes_lp];
  logic [7:0] shadow_mem [mem_bytes_lp];
  logic [63:0] ret_word_q [$];
  int ret_wait_q [$];
  msg_type_e exp_type_q [$];
  msg_size_e exp_size_q [$];
  msg_id_t exp_id_q [$];
  logic [27:0] exp_addr_q [$];
  logic [63:0] exp_data_q [$];
  int tagst_count;
  logic [31:0] stim_rng, cache_rng;
  bit slow_cache;

  mem_to_cache_bridge #(.data_width_p(64), .addr_width_p(28), .sets_p(8), .assoc_p(2),
    .fifo_els_p(fifo_els_lp)) uut (.*);

  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // low nbytes of the word repeated over all 8 bytes
  function automatic logic [63:0] replicate_low(input logic [63:0] word, input int nbytes);
    logic [63:0] r;
    for (int b = 0; b < 8; b++)
      r[8*b +: 8] = word[8*(b % nbytes) +: 8];
    return r;
  endfunction

  function automatic cache_opcode_e expected_opcode(input msg_type_e t, input msg_size_e s);
    cache_opcode_e op;
    case ({t, s})
      3'b000: op = LB;
      3'b001: op = LH;
      3'b010: op = LW;
      3'b011: op = LD;
      3'b100: op = SB;
      3'b101: op = SH;
      3'b110: op = SW;
      default: op = SD;
    endcase
    return op;
  endfunction

  // expected response data; stores update the shadow memory and answer zero
  function automatic logic [63:0] predict_resp(input msg_type_e t, input msg_size_e s,
                                               input logic [27:0] a, input logic [63:0] d);
    logic [63:0] loaded;
    int n;
    n = 1 << s;
    loaded = '0;
    for (int b = 0; b < n; b++)
    begin
      if (t == e_mem_wr)
        shadow_mem[a[7:0] + b] = d[8*b +: 8];
      else
        loaded[8*b +: 8] = shadow_mem[a[7:0] + b];
    end
    return replicate_low(loaded, n);
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic abort_run(input string what);
    $display("Error at %0t: %s", $time, what);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic offer_cmd(input msg_type_e t, input msg_size_e s, input msg_id_t id,
                           input logic [27:0] a, input logic [63:0] d);
    cmd_type_i = t;
    cmd_size_i = s;
    cmd_id_i   = id;
    cmd_addr_i = a;
    cmd_data_i = d;
    cmd_v_i    = 1'b1;
  endtask

  task automatic offer_random();
    logic [31:0] r;
    logic [7:0] mask;
    msg_size_e s;
    stim_rng = xorshift(stim_rng);
    r = stim_rng;
    s = msg_size_e'(r[1:0]);
    // align the address to the transfer size
    mask = 8'hff << s;
    stim_rng = xorshift(stim_rng);
    offer_cmd(msg_type_e'(r[2]), s, r[7:4], {20'b0, r[15:8] & mask}, {stim_rng, r});
  endtask

  // runs on the accepting edge and records what the response must be
  task automatic check_packet();
    cache_opcode_e exp_op;
    logic [63:0] exp_pkt;
    exp_op  = expected_opcode(cmd_type_i, cmd_size_i);
    exp_pkt = replicate_low(cmd_data_i, 1 << cmd_size_i);
    assert (cache_pkt_v_o) else abort_run("command accepted without a cache packet");
    assert (cache_opcode_o == exp_op)
      else report_mismatch("cache_opcode_o", cache_opcode_o, exp_op);
    assert (cache_addr_o == cmd_addr_i)
      else report_mismatch("cache_addr_o", cache_addr_o, cmd_addr_i);
    assert (cmd_type_i == e_mem_rd || cache_data_o == exp_pkt)
      else report_mismatch("cache_data_o", cache_data_o, exp_pkt);
    exp_type_q.push_back(cmd_type_i);
    exp_size_q.push_back(cmd_size_i);
    exp_id_q.push_back(cmd_id_i);
    exp_addr_q.push_back(cmd_addr_i);
    exp_data_q.push_back(predict_resp(cmd_type_i, cmd_size_i, cmd_addr_i, cmd_data_i));
  endtask

  task automatic wait_accept(input int limit, output bit taken);
    taken = 1'b0;
    for (int i = 0; i < limit && !taken; i++)
    begin
      @(posedge clk_i);
      if (cmd_ready_o)
      begin
        check_packet();
        taken = 1'b1;
      end
    end
    #1;
    if (taken)
      cmd_v_i = 1'b0;
  endtask

  task automatic finish_cmd();
    bit taken;
    wait_accept(500, taken);
    assert (taken) else abort_run("command not accepted before timeout");
  endtask

  task automatic wait_init();
    bit up;
    up = 1'b0;
    for (int i = 0; i < 200 && !up; i++)
    begin
      @(posedge clk_i);
      up = cmd_ready_o;
    end
    #1;
    assert (up) else abort_run("tag clearing did not finish before timeout");
    assert (tagst_count == lines_lp) else report_mismatch("TAGST count", tagst_count, lines_lp);
  endtask

  task automatic wait_drain();
    bit empty;
    empty = 1'b0;
    for (int i = 0; i < 3000 && !empty; i++)
    begin
      @(negedge clk_i);
      empty = (exp_data_q.size() == 0);
    end
    assert (empty) else abort_run("responses still outstanding after timeout");
    @(posedge clk_i);
    #1;
  endtask

  // in-order cache with a byte memory and a random reply delay
  always @(posedge clk_i)
  begin : cache_model
    logic [63:0] word;
    int n;
    if (!reset_i)
    begin
      if (cache_data_v_i && cache_data_yumi_o)
      begin
        void'(ret_word_q.pop_front());
        void'(ret_wait_q.pop_front());
      end
      if (ret_wait_q.size() != 0 && ret_wait_q[0] != 0)
        ret_wait_q[0] = ret_wait_q[0] - 1;
      if (cache_pkt_v_o && cache_pkt_ready_i)
      begin
        word = '0;
        case (cache_opcode_o)
          LB, SB: n = 1;
          LH, SH: n = 2;
          LW, SW: n = 4;
          default: n = 8;
        endcase
        if (cache_opcode_o == TAGST)
        begin
          assert (cache_addr_o == 28'(tagst_count * 64))
            else report_mismatch("cache_addr_o of TAGST", cache_addr_o, tagst_count * 64);
          assert (cache_data_o == '0) else report_mismatch("cache_data_o of TAGST", cache_data_o, 0);
          tagst_count++;
        end
        else
        begin
          for (int b = 0; b < n; b++)
            if (cache_opcode_o inside {SB, SH, SW, SD})
              cache_mem[cache_addr_o[7:0] + b] = cache_data_o[8*b +: 8];
            else
              word[8*b +: 8] = cache_mem[cache_addr_o[7:0] + b];
        end
        ret_word_q.push_back(word);
        ret_wait_q.push_back(slow_cache ? 6 + cache_rng % 8 : cache_rng % 3);
      end
    end
    #1;
    cache_rng = xorshift(cache_rng);
    cache_pkt_ready_i = slow_cache || (cache_rng[3:2] != 2'b00);
    resp_ready_i      = !slow_cache && (cache_rng[7:6] != 2'b00);
    cache_data_v_i    = (ret_wait_q.size() != 0) && (ret_wait_q[0] == 0);
    cache_data_i      = (ret_word_q.size() != 0) ? ret_word_q[0] : '0;
  end

  always @(posedge clk_i)
  begin : compare_resp
    logic [63:0] e_data;
    logic [27:0] e_addr;
    if (!reset_i && resp_v_o && resp_ready_i)
    begin
      assert (exp_data_q.size() != 0) else abort_run("response with no command outstanding");
      e_data = exp_data_q.pop_front();
      e_addr = exp_addr_q.pop_front();
      assert (resp_data_o == e_data) else report_mismatch("resp_data_o", resp_data_o, e_data);
      assert (resp_addr_o == e_addr) else report_mismatch("resp_addr_o", resp_addr_o, e_addr);
      assert (resp_id_o == exp_id_q[0]) else report_mismatch("resp_id_o", resp_id_o, exp_id_q[0]);
      assert (resp_type_o == exp_type_q[0])
        else report_mismatch("resp_type_o", resp_type_o, exp_type_q[0]);
      assert (resp_size_o == exp_size_q[0])
        else report_mismatch("resp_size_o", resp_size_o, exp_size_q[0]);
      void'(exp_id_q.pop_front());
      void'(exp_type_q.pop_front());
      void'(exp_size_q.pop_front());
    end
  end

  always @(negedge clk_i)
  begin
    if (uut.u_assertions.fail_count != 0)
      abort_run("a bound assertion failed");
  end

  initial
  begin
    bit taken;
    reset_i = 1'b1;
    cmd_v_i = 1'b0;
    offer_cmd(e_mem_rd, e_size_1, '0, '0, '0);
    cmd_v_i = 1'b0;
    cache_pkt_ready_i = 1'b0;
    cache_data_v_i = 1'b0;
    cache_data_i = '0;
    resp_ready_i = 1'b0;
    stim_rng = 32'd36152;
    cache_rng = xorshift(32'd36152);
    slow_cache = 1'b0;
    tagst_count = 0;
    for (int i = 0; i < mem_bytes_lp; i++)
    begin
      cache_mem[i]  = 8'(i * 29 + 7);
      shadow_mem[i] = 8'(i * 29 + 7);
    end
    repeat (4) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    wait_init();
    // store then load back at the same address, every size
    for (int s = 0; s < 4; s++)
    begin
      offer_cmd(e_mem_wr, msg_size_e'(s), 4'(s), 28'(64 + 8 * s), 64'h0123_4567_89ab_cdef + s);
      finish_cmd();
      offer_cmd(e_mem_rd, msg_size_e'(s), 4'(s + 8), 28'(64 + 8 * s), '0);
      finish_cmd();
    end
    for (int i = 0; i < 200; i++)
    begin
      offer_random();
      finish_cmd();
    end
    wait_drain();
    // with the consumer stalled the header FIFO fills and the next command waits
    slow_cache = 1'b1;
    for (int i = 0; i < fifo_els_lp; i++)
    begin
      offer_random();
      finish_cmd();
    end
    offer_random();
    wait_accept(40, taken);
    assert (!taken) else abort_run("command accepted while the response FIFO was full");
    slow_cache = 1'b0;
    finish_cmd();
    wait_drain();
    assert (tagst_count == lines_lp) else report_mismatch("TAGST count", tagst_count, lines_lp);
    if (uut.u_assertions.fail_count == 0)
    begin
      $display("Everything OK");
      $finish;
    end
    else
      abort_run("a bound assertion failed");
  end

endmodule

`default_nettype wire

//--- verilog.f
rtl/mem_msg_pkg.sv
rtl/cache_op_pkg.sv
rtl/cmd_to_cache_pkt.sv
rtl/resp_header_fifo.sv
rtl/tag_clear_seq.sv
rtl/mem_to_cache_bridge.sv
bench/bridge_assertions.sv
bench/bridge_tb.sv
